/* logic/arcade_pkg.sv */
`default_nettype none

package arcade_pkg;

	// keyboard scan codes, set 2
	localparam logic [7:0] KEY_UP = 8'h75;
	localparam logic [7:0] KEY_DOWN = 8'h72;
	localparam logic [7:0] KEY_LEFT = 8'h6B;
	localparam logic [7:0] KEY_RIGHT = 8'h74;
	localparam logic [7:0] KEY_COIN = 8'h76; // esc
	localparam logic [7:0] KEY_START1 = 8'h05; // f1
	localparam logic [7:0] KEY_START2 = 8'h06; // f2
	localparam logic [7:0] KEY_FIRE = 8'h29; // space
	localparam logic [7:0] KEY_BOMB = 8'h11; // alt

	// joystick byte bit positions
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT = 1;
	localparam int JOY_DOWN = 2;
	localparam int JOY_UP = 3;
	localparam int JOY_FIRE = 4;
	localparam int JOY_BOMB = 5;

	// menu status bits
	localparam int STATUS_RESET = 0;
	localparam int STATUS_MENU_RESET = 6;

	localparam int COLOR_IN_W = 4;
	localparam int COLOR_OUT_W = 6;
	localparam int DAC_W = 16;

	// game reset hold after the last source falls
	localparam int RESET_STRETCH = 16;
	localparam int RESET_CNT_W = $clog2(RESET_STRETCH + 1);
	localparam logic [RESET_CNT_W-1:0] RESET_LOAD = RESET_CNT_W'(RESET_STRETCH);

endpackage

`default_nettype wire

/* logic/ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if;
	logic up;
	logic down;
	logic left;
	logic right;
	logic fire;
	logic bomb;
	logic start1;
	logic start2;
	logic coin;

	modport source (
		output up, down, left, right, fire, bomb, start1, start2, coin
	);

	modport sink (
		input up, down, left, right, fire, bomb, start1, start2, coin
	);

endinterface

`default_nettype wire

/* logic/key_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module key_decoder (
	input wire logic clk_24,
	input wire logic rst_n,
	input wire logic key_strobe,
	input wire logic key_pressed,
	input wire logic [7:0] key_code,
	ctrl_if.source k
);

	logic strobe_q;
	logic key_event;

	assign key_event = (key_strobe != strobe_q); // any toggle is one event

	// strobe level from the previous edge
	always_ff @(posedge clk_24) begin
		strobe_q <= key_strobe;
	end

	always_ff @(posedge clk_24) begin
		if (!rst_n) begin
			k.up <= 1'b0;
			k.down <= 1'b0;
			k.left <= 1'b0;
			k.right <= 1'b0;
			k.fire <= 1'b0;
			k.bomb <= 1'b0;
			k.start1 <= 1'b0;
			k.start2 <= 1'b0;
			k.coin <= 1'b0;
		end else if (key_event) begin
			case (key_code)
				arcade_pkg::KEY_UP: k.up <= key_pressed;
				arcade_pkg::KEY_DOWN: k.down <= key_pressed;
				arcade_pkg::KEY_LEFT: k.left <= key_pressed;
				arcade_pkg::KEY_RIGHT: k.right <= key_pressed;
				arcade_pkg::KEY_FIRE: k.fire <= key_pressed;
				arcade_pkg::KEY_BOMB: k.bomb <= key_pressed;
				arcade_pkg::KEY_START1: k.start1 <= key_pressed;
				arcade_pkg::KEY_START2: k.start2 <= key_pressed;
				arcade_pkg::KEY_COIN: k.coin <= key_pressed;
				default: begin
					// unknown code, buttons hold
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/control_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module control_merge (
	input wire logic clk_24,
	input wire logic rst_n,
	ctrl_if.sink k,
	input wire logic [7:0] joystick_0,
	input wire logic [7:0] joystick_1,
	input wire logic [31:0] status,
	input wire logic board_button,
	ctrl_if.source g,
	output logic game_reset
);

	logic rst_src;
	logic [arcade_pkg::RESET_CNT_W-1:0] rst_cnt;

	assign rst_src = status[arcade_pkg::STATUS_RESET] | status[arcade_pkg::STATUS_MENU_RESET] |
		board_button;

	always_ff @(posedge clk_24) begin
		if (!rst_n) begin
			g.up <= 1'b0;
			g.down <= 1'b0;
			g.left <= 1'b0;
			g.right <= 1'b0;
			g.fire <= 1'b0;
			g.bomb <= 1'b0;
			g.start1 <= 1'b0;
			g.start2 <= 1'b0;
			g.coin <= 1'b0;
		end else begin
			g.up <= k.up | joystick_0[arcade_pkg::JOY_UP] | joystick_1[arcade_pkg::JOY_UP];
			g.down <= k.down | joystick_0[arcade_pkg::JOY_DOWN] | joystick_1[arcade_pkg::JOY_DOWN];
			g.left <= k.left | joystick_0[arcade_pkg::JOY_LEFT] | joystick_1[arcade_pkg::JOY_LEFT];
			g.right <= k.right | joystick_0[arcade_pkg::JOY_RIGHT] |
				joystick_1[arcade_pkg::JOY_RIGHT];
			g.fire <= k.fire | joystick_0[arcade_pkg::JOY_FIRE] | joystick_1[arcade_pkg::JOY_FIRE];
			g.bomb <= k.bomb | joystick_0[arcade_pkg::JOY_BOMB] | joystick_1[arcade_pkg::JOY_BOMB];
			g.start1 <= k.start1; // keys only
			g.start2 <= k.start2;
			g.coin <= k.coin;
		end
	end

	always_ff @(posedge clk_24) begin
		if (!rst_n || rst_src) begin
			rst_cnt <= arcade_pkg::RESET_LOAD; // reload while held
		end else if (rst_cnt != '0) begin
			rst_cnt <= rst_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk_24) begin
		if (!rst_n) begin
			game_reset <= 1'b1;
		end else begin
			game_reset <= rst_src | (rst_cnt != '0);
		end
	end

endmodule

`default_nettype wire

/* logic/video_out.sv */
`timescale 1ns/1ps
`default_nettype none

module video_out (
	input wire logic clk_24,
	input wire logic rst_n,
	input wire logic [arcade_pkg::COLOR_IN_W-1:0] r,
	input wire logic [arcade_pkg::COLOR_IN_W-1:0] g,
	input wire logic [arcade_pkg::COLOR_IN_W-1:0] b,
	input wire logic hs,
	input wire logic vs,
	input wire logic hb,
	input wire logic vb,
	output logic [arcade_pkg::COLOR_OUT_W-1:0] vga_r,
	output logic [arcade_pkg::COLOR_OUT_W-1:0] vga_g,
	output logic [arcade_pkg::COLOR_OUT_W-1:0] vga_b,
	output logic vga_hs,
	output logic vga_vs
);

	logic blank;

	// repeat the top bits into the new lsbs so full scale stays full scale
	function automatic logic [arcade_pkg::COLOR_OUT_W-1:0] widen(
		input logic [arcade_pkg::COLOR_IN_W-1:0] c
	);
		return {c, c[arcade_pkg::COLOR_IN_W-1 -: arcade_pkg::COLOR_OUT_W - arcade_pkg::COLOR_IN_W]};
	endfunction

	assign blank = hb | vb;

	always_ff @(posedge clk_24) begin
		if (!rst_n) begin
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			vga_r <= blank ? '0 : widen(r);
			vga_g <= blank ? '0 : widen(g);
			vga_b <= blank ? '0 : widen(b);
			vga_hs <= hs; // same stage as colour
			vga_vs <= vs;
		end
	end

endmodule

`default_nettype wire

/* logic/audio_dac.sv */
`timescale 1ns/1ps
`default_nettype none

module audio_dac (
	input wire logic clk_24,
	input wire logic rst_n,
	input wire logic [7:0] sample,
	output logic audio_out
);

	logic [arcade_pkg::DAC_W-1:0] dac_word;
	logic [arcade_pkg::DAC_W:0] acc;

	assign dac_word = {sample, sample}; // 8 to 16 bit full scale

	// first order: carry out of the running sum is the pulse stream
	always_ff @(posedge clk_24) begin
		if (!rst_n) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[arcade_pkg::DAC_W-1:0]} + {1'b0, dac_word};
		end
	end

	assign audio_out = acc[arcade_pkg::DAC_W]; // registered carry

endmodule

`default_nettype wire

/* logic/core_io_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_io_top (
	input wire logic clk_24,
	input wire logic rst_n,
	input wire logic key_strobe,
	input wire logic key_pressed,
	input wire logic [7:0] key_code,
	input wire logic [7:0] joystick_0,
	input wire logic [7:0] joystick_1,
	input wire logic [31:0] status,
	input wire logic board_button,
	input wire logic [arcade_pkg::COLOR_IN_W-1:0] r,
	input wire logic [arcade_pkg::COLOR_IN_W-1:0] g,
	input wire logic [arcade_pkg::COLOR_IN_W-1:0] b,
	input wire logic hs,
	input wire logic vs,
	input wire logic hb,
	input wire logic vb,
	input wire logic [7:0] sample,
	output logic up,
	output logic down,
	output logic left,
	output logic right,
	output logic fire,
	output logic bomb,
	output logic start1,
	output logic start2,
	output logic coin,
	output logic game_reset,
	output logic [arcade_pkg::COLOR_OUT_W-1:0] vga_r,
	output logic [arcade_pkg::COLOR_OUT_W-1:0] vga_g,
	output logic [arcade_pkg::COLOR_OUT_W-1:0] vga_b,
	output logic vga_hs,
	output logic vga_vs,
	output logic audio_out
);

	ctrl_if k_if (); // keyboard buttons
	ctrl_if g_if (); // merged game controls

	key_decoder u_key_decoder (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.key_strobe(key_strobe),
		.key_pressed(key_pressed),
		.key_code(key_code),
		.k(k_if)
	);

	control_merge u_control_merge (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.k(k_if),
		.joystick_0(joystick_0),
		.joystick_1(joystick_1),
		.status(status),
		.board_button(board_button),
		.g(g_if),
		.game_reset(game_reset)
	);

	assign up = g_if.up;
	assign down = g_if.down;
	assign left = g_if.left;
	assign right = g_if.right;
	assign fire = g_if.fire;
	assign bomb = g_if.bomb;
	assign start1 = g_if.start1;
	assign start2 = g_if.start2;
	assign coin = g_if.coin;

	video_out u_video_out (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.r(r),
		.g(g),
		.b(b),
		.hs(hs),
		.vs(vs),
		.hb(hb),
		.vb(vb),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs)
	);

	audio_dac u_audio_dac (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.sample(sample),
		.audio_out(audio_out)
	);

endmodule

`default_nettype wire

/* tb/core_io_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module core_io_checker (
	input wire logic clk_24, rst_n, board_button, hs, vga_hs, game_reset,
	input wire logic up, down, left, right, fire, bomb, start1, start2, coin
);

	logic [8:0] ctrl;

	assign ctrl = {up, down, left, right, fire, bomb, start1, start2, coin};

	// synchronous reset lands one edge later
	reset_state: assert property (@(posedge clk_24) !rst_n |=> (ctrl == '0 && game_reset))
		else $error("controls or game_reset wrong during reset");

	hs_delay: assert property (@(posedge clk_24) rst_n |=> (vga_hs == $past(hs)))
		else $error("vga_hs does not follow hs by one cycle");

	button_reset: assert property (@(posedge clk_24) rst_n && $rose(board_button) |=> game_reset)
		else $error("board button did not raise game_reset");

endmodule

`default_nettype wire

/* tb/core_io_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module core_io_monitor (
	input wire logic clk_24, rst_n, key_strobe, key_pressed, board_button,
	input wire logic [7:0] key_code, joystick_0, joystick_1,
	input wire logic [31:0] status,
	input wire logic [3:0] r, g, b,
	input wire logic hs, vs, hb, vb,
	input wire logic up, down, left, right, fire, bomb, start1, start2, coin, game_reset,
	input wire logic [5:0] vga_r, vga_g, vga_b,
	input wire logic vga_hs, vga_vs, audio_out,
	input wire logic test_done, count_en,
	input wire logic [3:0] test_kind,
	input wire logic [15:0] test_exp,
	output int err_total = 0,
	output int test_count = 0
);

	logic valid = 1'b0;
	logic strobe_seen, exp_gr;
	logic [8:0] kb, exp_ctrl, got_ctrl;
	logic [17:0] exp_vid;
	logic [1:0] exp_sync;
	int quiet, ones = 0, test_err = 0;

	assign got_ctrl = {up, down, left, right, fire, bomb, start1, start2, coin};

	task automatic report(input string what, input logic [31:0] exp, input logic [31:0] got);
		$display("ERR %0t: %s expected %0h got %0h", $time, what, exp, got);
		err_total++;
		test_err++;
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk_24) begin
		logic src;
		src = status[arcade_pkg::STATUS_RESET] | status[arcade_pkg::STATUS_MENU_RESET] |
			board_button;
		if (valid) begin
			if (got_ctrl !== exp_ctrl) report("controls", 32'(exp_ctrl), 32'(got_ctrl));
			if (game_reset !== exp_gr) report("game_reset", 32'(exp_gr), 32'(game_reset));
			if ({vga_r, vga_g, vga_b} !== exp_vid) report("colour", 32'(exp_vid),
				32'({vga_r, vga_g, vga_b}));
			if ({vga_hs, vga_vs} !== exp_sync) report("sync", 32'(exp_sync),
				32'({vga_hs, vga_vs}));
		end
		if (count_en && audio_out) ones++;
		if (test_done) begin
			test_count++;
			if (test_kind == 4'd0 && got_ctrl !== test_exp[8:0])
				report("held keys", 32'(test_exp), 32'(got_ctrl));
			if (test_kind == 4'd4 && ones != int'(test_exp))
				report("audio ones", 32'(test_exp), 32'(ones));
			$display("test %0d kind %0d: %s", test_count, test_kind,
				test_err == 0 ? "ok" : "failed");
			test_err = 0;
			ones = 0;
		end
		if (!rst_n) begin
			valid = 1'b1;
			kb = '0;
			exp_ctrl = '0;
			exp_gr = 1'b1; // reset counts as a source
			quiet = 0;
			exp_vid = '0;
			exp_sync = '0;
		end else begin
			exp_ctrl = {kb[8] | joystick_0[arcade_pkg::JOY_UP] | joystick_1[arcade_pkg::JOY_UP],
				kb[7] | joystick_0[arcade_pkg::JOY_DOWN] | joystick_1[arcade_pkg::JOY_DOWN],
				kb[6] | joystick_0[arcade_pkg::JOY_LEFT] | joystick_1[arcade_pkg::JOY_LEFT],
				kb[5] | joystick_0[arcade_pkg::JOY_RIGHT] | joystick_1[arcade_pkg::JOY_RIGHT],
				kb[4] | joystick_0[arcade_pkg::JOY_FIRE] | joystick_1[arcade_pkg::JOY_FIRE],
				kb[3] | joystick_0[arcade_pkg::JOY_BOMB] | joystick_1[arcade_pkg::JOY_BOMB],
				kb[2:0]};
			quiet = src ? 0 : (quiet < 1000 ? quiet + 1 : quiet); // cycles since last source
			exp_gr = (quiet <= arcade_pkg::RESET_STRETCH);
			exp_vid = (hb | vb) ? '0 : {r, r[3:2], g, g[3:2], b, b[3:2]};
			exp_sync = {hs, vs};
			if (key_strobe != strobe_seen) begin
				case (key_code)
					arcade_pkg::KEY_UP: kb[8] = key_pressed;
					arcade_pkg::KEY_DOWN: kb[7] = key_pressed;
					arcade_pkg::KEY_LEFT: kb[6] = key_pressed;
					arcade_pkg::KEY_RIGHT: kb[5] = key_pressed;
					arcade_pkg::KEY_FIRE: kb[4] = key_pressed;
					arcade_pkg::KEY_BOMB: kb[3] = key_pressed;
					arcade_pkg::KEY_START1: kb[2] = key_pressed;
					arcade_pkg::KEY_START2: kb[1] = key_pressed;
					arcade_pkg::KEY_COIN: kb[0] = key_pressed;
					default: kb = kb;
				endcase
			end
		end
		strobe_seen = key_strobe;
	end

endmodule

`default_nettype wire

/* tb/tb_core_io.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core_io;

	localparam int N = 32;
	localparam int AUDIO_N = 4;
	localparam int LIMIT = 8 + AUDIO_N * 65536 + 64 * N + 200;

	// {kind, stimulus, expected}, kinds: 0 key {pressed, code} / held controls,
	// 1 joystick, 2 reset source, 3 video blanking, 4 audio sample / count of ones
	localparam logic [31:0] TABLE [0:N-1] = '{
		32'h0175_0100, 32'h0172_0180, 32'h016B_01C0, 32'h0174_01E0,
		32'h0129_01F0, 32'h0111_01F8, 32'h0105_01FC, 32'h0106_01FE,
		32'h0176_01FF, 32'h011A_01FF, 32'h0075_00FF, 32'h0072_007F,
		32'h006B_003F, 32'h0074_001F, 32'h1000_0000, 32'h1000_0000,
		32'h1000_0000, 32'h0029_000F, 32'h0011_0007, 32'h0005_0003,
		32'h0006_0001, 32'h0076_0000, 32'h2000_0000, 32'h2001_0000,
		32'h2002_0000, 32'h3000_0000, 32'h3001_0000, 32'h3002_0000,
		32'h4000_0000, 32'h4080_8080, 32'h403C_3C3C, 32'h40FF_FFFF
	};

	logic clk_24 = 1'b0;
	logic rst_n, key_strobe, key_pressed, board_button;
	logic [7:0] key_code, joystick_0, joystick_1, sample;
	logic [31:0] status;
	logic [3:0] r, g, b;
	logic hs, vs, hb, vb;
	logic up, down, left, right, fire, bomb, start1, start2, coin, game_reset;
	logic [5:0] vga_r, vga_g, vga_b;
	logic vga_hs, vga_vs, audio_out;
	logic test_done, count_en;
	logic [3:0] test_kind;
	logic [15:0] test_exp;
	int err_total, test_count;
	int cycles = 0;

	always #20 clk_24 = ~clk_24;

	core_io_top uut (.*);
	core_io_monitor mon (.*);
	bind core_io_top core_io_checker chk (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	always @(posedge clk_24) begin
		cycles <= cycles + 1;
		if (cycles > LIMIT) begin
			$display("timeout: run still busy after %0d cycles", LIMIT);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial begin
		logic [31:0] ent;
		logic [31:0] rnd;
		int len;
		rst_n <= 1'b0;
		key_strobe <= 1'b0;
		key_pressed <= 1'b0;
		key_code <= '0;
		joystick_0 <= '0;
		joystick_1 <= '0;
		status <= '0;
		board_button <= 1'b0;
		{r, g, b, hs, vs, hb, vb} <= '0;
		sample <= '0;
		{test_done, count_en, test_kind, test_exp} <= '0;
		rnd = 32'hdaa6;
		repeat (8) @(posedge clk_24);
		rst_n <= 1'b1;
		repeat (arcade_pkg::RESET_STRETCH + 4) @(posedge clk_24); // let game_reset fall
		for (int i = 0; i < N; i++) begin
			ent = TABLE[i];
			test_kind <= ent[31:28];
			test_exp <= ent[15:0];
			case (ent[31:28])
				4'd0: begin
					key_code <= ent[23:16];
					key_pressed <= ent[24];
					key_strobe <= ~key_strobe; // one event
					repeat (4) @(posedge clk_24);
				end
				4'd1: begin
					repeat (8) begin
						rnd = lcg_next(rnd);
						joystick_0 <= rnd[23:16];
						rnd = lcg_next(rnd);
						joystick_1 <= rnd[23:16];
						@(posedge clk_24);
					end
					joystick_0 <= '0;
					joystick_1 <= '0;
					repeat (2) @(posedge clk_24);
				end
				4'd2: begin
					rnd = lcg_next(rnd);
					len = int'(rnd[19:16]) + 1;
					case (ent[17:16])
						2'd0: status[arcade_pkg::STATUS_RESET] <= 1'b1;
						2'd1: status[arcade_pkg::STATUS_MENU_RESET] <= 1'b1;
						default: board_button <= 1'b1;
					endcase
					repeat (len) @(posedge clk_24);
					status <= '0;
					board_button <= 1'b0;
					repeat (arcade_pkg::RESET_STRETCH + 4) @(posedge clk_24);
				end
				4'd3: begin
					repeat (8) begin
						rnd = lcg_next(rnd);
						{vs, hs, b, g, r} <= rnd[29:16];
						hb <= ent[16];
						vb <= ent[17];
						@(posedge clk_24);
					end
					hb <= 1'b0;
					vb <= 1'b0;
					repeat (2) @(posedge clk_24);
				end
				default: begin
					sample <= ent[23:16];
					repeat (4) @(posedge clk_24);
					count_en <= 1'b1;
					repeat (65536) @(posedge clk_24); // one full modulator period
					count_en <= 1'b0;
					repeat (2) @(posedge clk_24);
				end
			endcase
			test_done <= 1'b1;
			@(posedge clk_24);
			test_done <= 1'b0;
		end
		repeat (4) @(posedge clk_24);
		$display("tests run %0d of %0d, errors %0d", test_count, N, err_total);
		if (err_total == 0 && test_count == N) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
logic/arcade_pkg.sv
logic/ctrl_if.sv
logic/key_decoder.sv
logic/control_merge.sv
logic/video_out.sv
logic/audio_dac.sv
logic/core_io_top.sv
tb/core_io_checker.sv
tb/core_io_monitor.sv
tb/tb_core_io.sv

/* Makefile */
TOP = tb_core_io
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
